// File: logic/scatter_pkg.sv
package scatter_pkg;

    // element and vector geometry
    // the vector typedefs below are built on these two
    localparam int ELEM_W    = 8;
    localparam int NUM_ELEMS = 8;

    // top level defaults
    localparam int DEF_HIGH_SLOTS  = 2;
    localparam int DEF_MSB_DEPTH   = 3;
    localparam int DEF_BUF_DEPTH   = 4;
    localparam int DEF_OUT_CREDITS = 2;

    // one signed element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // one tensor vector, element 0 in the low bits
    typedef elem_t [NUM_ELEMS-1:0] vec_t;

    // 1 marks an outlier slot
    typedef logic [NUM_ELEMS-1:0] mask_t;

    // saturated magnitude, sign bit dropped
    typedef logic [ELEM_W-2:0] mag_t;

    // wide enough for either credit pool
    typedef logic [3:0] credit_t;

    // beat tag between decode and split
    typedef logic [1:0] stage_id_t;

endpackage

// File: logic/scatter_if.sv
`timescale 1ns/1ps

// decode stage to split stage
// no back-pressure, every valid beat is taken
interface decoded_if import scatter_pkg::*; ();

    logic      valid;
    vec_t      data;
    mask_t     mask;
    // running beat tag from the decode stage
    stage_id_t stage_id;

    modport producer (
        output valid,
        output data,
        output mask,
        output stage_id
    );

    modport consumer (
        input valid,
        input data,
        input mask,
        input stage_id
    );

endinterface

// split stage to result stage
interface split_if import scatter_pkg::*; ();

    logic  valid;
    vec_t  high;
    vec_t  low;
    mask_t mask;

    modport producer (
        output valid,
        output high,
        output low,
        output mask
    );

    modport consumer (
        input valid,
        input high,
        input low,
        input mask
    );

endinterface

// File: logic/outlier_decode.sv
`timescale 1ns/1ps

module outlier_decode import scatter_pkg::*; #(
    parameter int HIGH_SLOTS = DEF_HIGH_SLOTS,
    parameter int MSB_DEPTH  = DEF_MSB_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  vec_t               in_data,
    decoded_if.producer        dec
);

    localparam int MAG_W = ELEM_W - 1;
    // rank count has to reach NUM_ELEMS-1 and compare against HIGH_SLOTS
    localparam int CNT_W = $clog2(NUM_ELEMS) + 1;
    // -2^(ELEM_W-1) has no positive twin
    localparam elem_t MOST_NEG = {1'b1, {(ELEM_W-1){1'b0}}};

    mag_t                 mag    [NUM_ELEMS];
    logic [MSB_DEPTH-1:0] coarse [NUM_ELEMS];
    logic [CNT_W-1:0]     above  [NUM_ELEMS];
    mask_t                mask_n;
    stage_id_t            seq_q;

    // saturating abs, then keep only the top bits
    // fewer bits in the compare tree saves power
    always_comb begin
        for (int i = 0; i < NUM_ELEMS; i++) begin
            if (in_data[i] == MOST_NEG) begin
                // clamp to the largest magnitude
                mag[i] = '1;
            end else if (in_data[i][ELEM_W-1]) begin
                mag[i] = mag_t'(-in_data[i]);
            end else begin
                mag[i] = mag_t'(in_data[i]);
            end
            coarse[i] = mag[i][MAG_W-1 -: MSB_DEPTH];
        end
    end

    // n largest selection
    // count the elements ranked strictly above element i
    // higher coarse magnitude wins, a tie goes to the lower index
    // exactly HIGH_SLOTS elements end up with a count below HIGH_SLOTS
    always_comb begin
        for (int i = 0; i < NUM_ELEMS; i++) begin
            above[i] = '0;
            for (int j = 0; j < NUM_ELEMS; j++) begin
                if (coarse[j] > coarse[i]) begin
                    above[i] = above[i] + 1'b1;
                end else if (coarse[j] == coarse[i] && j < i) begin
                    // j == i never counts here
                    above[i] = above[i] + 1'b1;
                end
            end
            mask_n[i] = (above[i] < CNT_W'(HIGH_SLOTS));
        end
    end

    // stage register, control part
    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
            seq_q     <= '0;
        end else begin
            dec.valid <= in_valid;
            if (in_valid) begin
                seq_q <= seq_q + 1'b1;
            end
        end
    end

    // stage register, payload part
    // data, mask and tag load together on a beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.data     <= in_data;
            dec.mask     <= mask_n;
            dec.stage_id <= seq_q;
        end
    end

endmodule

// File: logic/precision_split.sv
`timescale 1ns/1ps

module precision_split import scatter_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    decoded_if.consumer dec,
    split_if.producer   spl
);

    vec_t      high_n;
    vec_t      low_n;
    logic      take;

    // route each slot by its mask bit
    // high keeps the outliers, low keeps the rest
    // high | low gives the input back
    always_comb begin
        for (int i = 0; i < NUM_ELEMS; i++) begin
            if (dec.mask[i]) begin
                high_n[i] = dec.data[i];
                low_n[i]  = '0;
            end else begin
                high_n[i] = '0;
                low_n[i]  = dec.data[i];
            end
        end
    end

    // no back-pressure, every decoded beat is taken
    assign take = dec.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            spl.valid <= 1'b0;
        end else begin
            spl.valid <= take;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (take) begin
            spl.high <= high_n;
            spl.low  <= low_n;
            spl.mask <= dec.mask;
        end
    end

endmodule

// File: logic/scatter_result.sv
`timescale 1ns/1ps

module scatter_result import scatter_pkg::*; #(
    parameter int BUF_DEPTH   = DEF_BUF_DEPTH,
    parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
    input  logic      clk,
    input  logic      rst,
    split_if.consumer spl,
    output logic      out_valid,
    output vec_t      out_high,
    output vec_t      out_low,
    output mask_t     out_mask,
    input  logic      out_credit,
    output logic      in_credit
);

    localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CW = $clog2(BUF_DEPTH + 1);

    // fifo storage
    vec_t  high_mem [BUF_DEPTH];
    vec_t  low_mem  [BUF_DEPTH];
    mask_t mask_mem [BUF_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    credit_t       credits;
    logic          push;
    logic          pop;

    // no room check on push
    // upstream never holds more than BUF_DEPTH credits
    assign push = spl.valid;
    // send needs an entry and a downstream credit
    assign pop  = (count != '0) && (credits != '0);

    // fifo write, payload only
    always_ff @(posedge clk) begin
        if (push) begin
            high_mem[wr_ptr] <= spl.high;
            low_mem[wr_ptr]  <= spl.low;
            mask_mem[wr_ptr] <= spl.mask;
        end
    end

    // pointers, occupancy and credits
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= credit_t'(OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // a returned credit and a send in one cycle cancel
            if (pop && !out_credit) begin
                credits <= credits - 1'b1;
            end else if (out_credit && !pop) begin
                credits <= credits + 1'b1;
            end
        end
    end

    // output strobes, one cycle per vector
    // in_credit goes out with out_valid so upstream regains the slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    // output payload registers
    always_ff @(posedge clk) begin
        if (pop) begin
            out_high <= high_mem[rd_ptr];
            out_low  <= low_mem[rd_ptr];
            out_mask <= mask_mem[rd_ptr];
        end
    end

endmodule

// File: logic/scatter_top.sv
`timescale 1ns/1ps

module scatter_top import scatter_pkg::*; #(
    parameter int HIGH_SLOTS  = DEF_HIGH_SLOTS,
    parameter int MSB_DEPTH   = DEF_MSB_DEPTH,
    parameter int BUF_DEPTH   = DEF_BUF_DEPTH,
    parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
    input  logic  clk,
    input  logic  rst,
    // upstream, credit based
    input  logic  in_valid,
    input  vec_t  in_data,
    output logic  in_credit,
    // downstream, credit based
    output logic  out_valid,
    output vec_t  out_high,
    output vec_t  out_low,
    output mask_t out_mask,
    input  logic  out_credit
);

    decoded_if dec_bus ();
    split_if   spl_bus ();

    // decode, abs and outlier mask
    outlier_decode #(
        .HIGH_SLOTS (HIGH_SLOTS),
        .MSB_DEPTH  (MSB_DEPTH)
    ) i_outlier_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .dec      (dec_bus.producer)
    );

    // execute, high and low arrays
    precision_split i_precision_split (
        .clk (clk),
        .rst (rst),
        .dec (dec_bus.consumer),
        .spl (spl_bus.producer)
    );

    // result, buffer and both credit loops
    scatter_result #(
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_scatter_result (
        .clk        (clk),
        .rst        (rst),
        .spl        (spl_bus.consumer),
        .out_valid  (out_valid),
        .out_high   (out_high),
        .out_low    (out_low),
        .out_mask   (out_mask),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

endmodule

// File: bench/scatter_tb.sv
`timescale 1ns/1ps

module scatter_tb import scatter_pkg::*; ();

    localparam int HIGH_SLOTS  = DEF_HIGH_SLOTS;
    localparam int MSB_DEPTH   = DEF_MSB_DEPTH;
    localparam int BUF_DEPTH   = DEF_BUF_DEPTH;
    localparam int OUT_CREDITS = DEF_OUT_CREDITS;
    localparam int CLK_NS      = 40;
    localparam int NFIX        = 5;
    localparam int NROWS       = 16;
    // 40 cycles per row plus margin
    localparam int WATCH_NS    = NROWS * 40 * CLK_NS + 2000;

    logic  clk;
    logic  rst;
    logic  in_valid;
    vec_t  in_data;
    logic  in_credit;
    logic  out_valid;
    vec_t  out_high;
    vec_t  out_low;
    mask_t out_mask;
    logic  out_credit;

    // zeros, all equal, most negative, three way tie, truncation tie
    vec_t  fix_vec  [NFIX] = '{64'h0, 64'h5555_5555_5555_5555, 64'h1010_8010_1040_1010,
                               64'h0090_0000_9000_7f00, 64'h7f00_0070_0000_006f};
    mask_t fix_mask [NFIX] = '{8'h03, 8'h03, 8'h24, 8'h0a, 8'h90};
    // consumer credit return delay per row, in cycles
    int    stall    [NROWS] = '{1, 0, 5, 30, 2, 0, 1, 25, 3, 0, 0, 4, 1, 2, 0, 6};

    vec_t        stim_vec  [NROWS];
    mask_t       stim_mask [NROWS];
    int          exp_rows  [$];
    int          pend      [$];
    logic [31:0] seed = 32'h3e59;
    int errors = 0;
    int tx = 0;
    int rx = 0;
    int cycle = 0;
    int up_credits = BUF_DEPTH;
    int up_returned = 0;
    int cons_credits = OUT_CREDITS;

    scatter_top #(
        .HIGH_SLOTS  (HIGH_SLOTS),
        .MSB_DEPTH   (MSB_DEPTH),
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_scatter_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_high   (out_high),
        .out_low    (out_low),
        .out_mask   (out_mask),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference ranking: coarse magnitude first, then lower index
    function automatic mask_t ref_mask(input vec_t v);
        int    crs [NUM_ELEMS];
        int    m;
        int    cnt;
        mask_t r;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            m = int'(v[i]);
            m = (m < 0) ? -m : m;
            // saturate, -128 has no positive twin
            m = (m > 127) ? 127 : m;
            crs[i] = m >> (ELEM_W - 1 - MSB_DEPTH);
        end
        for (int i = 0; i < NUM_ELEMS; i++) begin
            cnt = 0;
            for (int j = 0; j < NUM_ELEMS; j++) begin
                if (crs[j] > crs[i] || (crs[j] == crs[i] && j < i)) cnt++;
            end
            r[i] = (cnt < HIGH_SLOTS);
        end
        return r;
    endfunction

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("FAIL %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // compare one output beat against the oldest outstanding row
    task automatic check_output();
        int   row;
        int   err_before;
        vec_t hi;
        vec_t lo;
        err_before = errors;
        expect_true(exp_rows.size() > 0, "output beat with no input outstanding");
        if (exp_rows.size() > 0) begin
            row = exp_rows.pop_front();
            for (int i = 0; i < NUM_ELEMS; i++) begin
                hi[i] = stim_mask[row][i] ? stim_vec[row][i] : '0;
                lo[i] = stim_mask[row][i] ? '0 : stim_vec[row][i];
            end
            expect_true(cons_credits > 0, "out_valid with no consumer credit");
            expect_true(out_mask == stim_mask[row], "out_mask differs from expected");
            expect_true($countones(out_mask) == HIGH_SLOTS, "wrong outlier count");
            expect_true(out_high == hi, "out_high differs from expected");
            expect_true(out_low == lo, "out_low differs from expected");
            expect_true((out_high | out_low) == stim_vec[row], "high and low lose input");
            // consumer hands the credit back after the row's stall
            pend.push_back(cycle + stall[row]);
            $display("row %0d: %s", row, (errors == err_before) ? "ok" : "mismatch");
        end
        cons_credits--;
        rx++;
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        for (int r = 0; r < NFIX; r++) begin
            stim_vec[r]  = fix_vec[r];
            stim_mask[r] = fix_mask[r];
        end
        for (int r = NFIX; r < NROWS; r++) begin
            seed = xorshift(seed);
            stim_vec[r][3:0] = seed;
            seed = xorshift(seed);
            stim_vec[r][7:4] = seed;
            stim_mask[r] = ref_mask(stim_vec[r]);
        end
        repeat (3) begin
            @(posedge clk);
            #2;
            expect_true(!out_valid && !in_credit, "strobe high during reset");
        end
        rst = 1'b0;
        while (rx < NROWS) begin
            @(posedge clk);
            #2;
            cycle++;
            expect_true(in_credit == out_valid, "in_credit not aligned with out_valid");
            if (in_credit) begin
                up_credits++;
                up_returned++;
            end
            // a returned slot must match a vector that was sent
            expect_true(up_credits <= BUF_DEPTH, "in_credit returned a slot never spent");
            if (out_valid) check_output();
            // pulse driven last cycle was taken at this edge
            if (out_credit) cons_credits++;
            out_credit = 1'b0;
            if (pend.size() > 0 && pend[0] <= cycle) begin
                out_credit = 1'b1;
                void'(pend.pop_front());
            end
            // producer spends one credit per beat
            in_valid = 1'b0;
            if (tx < NROWS && up_credits > 0) begin
                in_valid = 1'b1;
                in_data  = stim_vec[tx];
                exp_rows.push_back(tx);
                up_credits--;
                tx++;
            end
        end
        expect_true(up_returned == rx, "in_credit pulses differ from output beats");
        $display("tests %0d, received %0d, errors %0d", NROWS, rx, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCH_NS);
        $display("timeout: only %0d of %0d vectors came out", rx, NROWS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog.f
logic/scatter_pkg.sv
logic/scatter_if.sv
logic/outlier_decode.sv
logic/precision_split.sv
logic/scatter_result.sv
logic/scatter_top.sv
bench/scatter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the scatter unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f verilog.f \
    --top-module scatter_tb -o scatter_sim > build.log 2>&1 \
    && ./obj_dir/scatter_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or run failed"; exit 1; }

cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "no result line, run incomplete"; exit 1; }
echo "simulation passed"
